//--- include/safe_ctrl_macros.svh
/* Cluster size and safe configuration codes for the lockstep controller.
   Changing SAFE_NHARTS resizes hart_vec_t and every per-core vector. */

`ifndef SAFE_CTRL_MACROS_SVH
`define SAFE_CTRL_MACROS_SVH

// Number of lockstep cores
`define SAFE_NHARTS 3

//////////////////////////////////////////////////
// Safe configuration codes
//////////////////////////////////////////////////
`define SAFE_CFG_SINGLE 2'b00 // Not TMR, ignored by the controller
`define SAFE_CFG_TMR    2'b01

// Scenario steps run by the testbench
`define SAFE_TB_STEPS 6

`endif

//--- rtl/safe_ctrl_pkg.sv
/* Shared types of the lockstep controller.
   Vector width follows SAFE_NHARTS from the macro header. */

`include "safe_ctrl_macros.svh"

package safe_ctrl_pkg;

  // One bit per core
  typedef logic [`SAFE_NHARTS-1:0] hart_vec_t;

  typedef logic [1:0] safe_cfg_t;

  // Cluster mode sequencing
  typedef enum logic [3:0] {
    MODE_RESET,
    MODE_BOOT,
    MODE_IDLE,
    MODE_TMR
  } mode_state_e;

  // Per-core TMR sequencing
  typedef enum logic [3:0] {
    TMR_RESET,
    TMR_IDLE,
    TMR_START,
    TMR_BOOT,
    TMR_SYNC,
    TMR_SYNCINTC,
    TMR_SWSYNC
  } tmr_state_e;

endpackage

//--- rtl/safety_mode_fsm.sv
`timescale 1ns/1ps
/* Cluster mode FSM. Holds the cluster in boot until every core waits for
   interrupt. Only the TMR code leaves idle; other codes are ignored.
   TMR mode ends once all cores are idle and start is low. */

`include "safe_ctrl_macros.svh"

module safety_mode_fsm (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      start_i,
  input  safe_ctrl_pkg::safe_cfg_t  safe_cfg_i,
  input  safe_ctrl_pkg::hart_vec_t  hart_wfi_i,
  input  safe_ctrl_pkg::hart_vec_t  harts_idle_i,
  output logic                      tmr_run_o,
  output logic                      boot_o,
  output logic                      en_ext_debug_req_o
);

  import safe_ctrl_pkg::*;

  mode_state_e state_q, state_d;

  logic all_wfi;
  logic all_idle;
  logic tmr_req;

  assign all_wfi  = &hart_wfi_i;
  assign all_idle = &harts_idle_i;
  assign tmr_req  = start_i && (safe_cfg_i == `SAFE_CFG_TMR);

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      state_q <= MODE_RESET;
    else
      state_q <= state_d;
  end

  //////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////
  always_comb
  begin
    state_d = state_q;
    unique case (state_q)
      MODE_RESET:
        state_d = MODE_BOOT; // Single power-on cycle
      MODE_BOOT:
      begin
        if (all_wfi)
          state_d = MODE_IDLE;
      end
      MODE_IDLE:
      begin
        if (tmr_req)
          state_d = MODE_TMR;
      end
      MODE_TMR:
      begin
        // Wait for every core FSM to settle back in idle
        if (all_idle && !start_i)
          state_d = MODE_IDLE;
      end
      default:
        state_d = MODE_IDLE;
    endcase
  end

  // Core FSMs see the run level only while start is held
  assign tmr_run_o          = (state_q == MODE_TMR) && start_i;
  assign boot_o             = (state_q == MODE_BOOT);
  assign en_ext_debug_req_o = (state_q == MODE_IDLE); // Debug allowed only when idle

endmodule

//--- rtl/tmr_hart_fsm.sv
`timescale 1ns/1ps
/* TMR sequencing for one core: halt, boot, synchronized run.
   Halt ack must rise and then fall before the core counts as synced.
   A resync needs every core to raise and then drop its interrupt ack. */

module tmr_hart_fsm (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      tmr_run_i,
  input  logic                      halt_ack_i,       // This core only
  input  logic                      tmr_error_i,      // Filtered voter error
  input  logic                      end_sw_routine_i,
  input  safe_ctrl_pkg::hart_vec_t  hart_wfi_i,
  input  safe_ctrl_pkg::hart_vec_t  hart_intc_ack_i,
  output logic                      halt_req_o,
  output logic                      boot_o,
  output logic                      bus_merge_o,
  output logic                      voter_enable_o,
  output logic                      resync_irq_o,
  output logic                      idle_o,
  output logic                      in_sync_o
);

  import safe_ctrl_pkg::*;

  tmr_state_e state_q, state_d;

  logic all_wfi;
  logic all_ack;
  logic none_ack;

  assign all_wfi  = &hart_wfi_i;
  assign all_ack  = &hart_intc_ack_i;
  assign none_ack = ~|hart_intc_ack_i;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      state_q <= TMR_RESET;
    else
      state_q <= state_d;
  end

  //////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////
  always_comb
  begin
    state_d = state_q;
    unique case (state_q)
      TMR_RESET:
        state_d = TMR_IDLE;
      TMR_IDLE:
      begin
        if (tmr_run_i)
          state_d = TMR_START;
      end
      TMR_START:
      begin
        if (halt_ack_i)
          state_d = TMR_BOOT;
      end
      TMR_BOOT:
      begin
        if (!halt_ack_i)
          state_d = TMR_SYNC; // Core left debug mode in lockstep
      end
      TMR_SYNC:
      begin
        // Orderly end wins over a late voter error
        if (all_wfi && end_sw_routine_i)
          state_d = TMR_IDLE;
        else if (tmr_error_i)
          state_d = TMR_SYNCINTC;
      end
      TMR_SYNCINTC:
      begin
        if (all_ack)
          state_d = TMR_SWSYNC;
      end
      TMR_SWSYNC:
      begin
        if (none_ack)
          state_d = TMR_SYNC; // Software restored its context
      end
      default:
        state_d = TMR_IDLE;
    endcase
  end

  //////////////////////////////////////////////////
  // Outputs, decoded from state only
  //////////////////////////////////////////////////
  always_comb
  begin
    halt_req_o   = 1'b0;
    boot_o       = 1'b0;
    resync_irq_o = 1'b0;
    unique case (state_q)
      TMR_START:
      begin
        halt_req_o = 1'b1;
        boot_o     = 1'b1;
      end
      TMR_BOOT:
        boot_o = 1'b1;
      TMR_SYNCINTC, TMR_SWSYNC:
        resync_irq_o = 1'b1;
      default:
        boot_o = 1'b0;
    endcase
  end

  assign bus_merge_o    = (state_q != TMR_RESET) && (state_q != TMR_IDLE);
  assign voter_enable_o = (state_q != TMR_RESET) && (state_q != TMR_IDLE);
  assign idle_o         = (state_q == TMR_IDLE);
  assign in_sync_o      = (state_q == TMR_SYNC);

endmodule

//--- rtl/tmr_error_filter.sv
`timescale 1ns/1ps
/* Voter error filter for synchronized run.
   Inside a critical section the first error edge is swallowed and only
   the second one is forwarded. State clears once any core leaves SYNC. */

module tmr_error_filter (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      tmr_error_i,
  input  logic                      tmr_critical_section_i,
  input  safe_ctrl_pkg::hart_vec_t  in_sync_i,
  output logic                      tmr_error_o
);

  logic err_q;    // Previous error sample
  logic edge_q;   // Toggles on every rising edge
  logic err_rise;

  assign err_rise = tmr_error_i && !err_q;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      err_q  <= 1'b0;
      edge_q <= 1'b0;
    end
    else if ((|in_sync_i) && err_rise)
    begin
      err_q  <= tmr_error_i;
      edge_q <= !edge_q;
    end
    else if (!(&in_sync_i))
    begin
      err_q  <= 1'b0; // Error still high on re-entry counts as new edge
      edge_q <= 1'b0;
    end
    else
      err_q <= tmr_error_i;
  end

  // Second edge in critical section, else raw error or pending edge
  assign tmr_error_o = tmr_critical_section_i ? (err_rise && edge_q)
                                              : (tmr_error_i || edge_q);

endmodule

//--- rtl/safe_mode_ctrl.sv
`timescale 1ns/1ps
/* Lockstep safety-mode controller, TMR only.
   NHARTS must equal SAFE_NHARTS, which sets the width of hart_vec_t.
   Non-TMR configuration codes keep the controller idle. */

`include "safe_ctrl_macros.svh"

module safe_mode_ctrl #(
  parameter int NHARTS = `SAFE_NHARTS
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      start_i,
  input  safe_ctrl_pkg::safe_cfg_t  safe_cfg_i,
  input  logic                      tmr_critical_section_i,
  input  logic                      tmr_error_i,
  input  logic                      end_sw_routine_i,
  input  safe_ctrl_pkg::hart_vec_t  halt_ack_i,
  input  safe_ctrl_pkg::hart_vec_t  hart_wfi_i,
  input  safe_ctrl_pkg::hart_vec_t  hart_intc_ack_i,
  output safe_ctrl_pkg::hart_vec_t  interrupt_halt_o,
  output safe_ctrl_pkg::hart_vec_t  interrupt_swresync_o,
  output logic                      single_bus_o,
  output logic                      tmr_voter_enable_o,
  output logic                      start_boot_o,
  output logic                      en_ext_debug_req_o
);

  import safe_ctrl_pkg::*;

  logic      tmr_run;
  logic      mode_boot;
  logic      tmr_error_filt;
  hart_vec_t harts_idle, harts_in_sync;
  hart_vec_t hart_boot, hart_bus_merge, hart_voter_en;

  if (NHARTS != `SAFE_NHARTS)
  begin : g_nharts_check
    $error("NHARTS differs from SAFE_NHARTS");
  end

  safety_mode_fsm u_mode_fsm (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .start_i            (start_i),
    .safe_cfg_i         (safe_cfg_i),
    .hart_wfi_i         (hart_wfi_i),
    .harts_idle_i       (harts_idle),
    .tmr_run_o          (tmr_run),
    .boot_o             (mode_boot),
    .en_ext_debug_req_o (en_ext_debug_req_o)
  );

  tmr_error_filter u_error_filter (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .tmr_error_i            (tmr_error_i),
    .tmr_critical_section_i (tmr_critical_section_i),
    .in_sync_i              (harts_in_sync),
    .tmr_error_o            (tmr_error_filt)
  );

  //////////////////////////////////////////////////
  // One TMR FSM per core
  //////////////////////////////////////////////////
  for (genvar i = 0; i < NHARTS; i++)
  begin : g_hart
    tmr_hart_fsm u_hart_fsm (
      .clk_i            (clk_i),
      .rst_ni           (rst_ni),
      .tmr_run_i        (tmr_run),
      .halt_ack_i       (halt_ack_i[i]),
      .tmr_error_i      (tmr_error_filt),
      .end_sw_routine_i (end_sw_routine_i),
      .hart_wfi_i       (hart_wfi_i),
      .hart_intc_ack_i  (hart_intc_ack_i),
      .halt_req_o       (interrupt_halt_o[i]),
      .boot_o           (hart_boot[i]),
      .bus_merge_o      (hart_bus_merge[i]),
      .voter_enable_o   (hart_voter_en[i]),
      .resync_irq_o     (interrupt_swresync_o[i]),
      .idle_o           (harts_idle[i]),
      .in_sync_o        (harts_in_sync[i])
    );
  end

  // Boot phase keeps bus merged and voter on
  assign single_bus_o       = (|hart_bus_merge) || mode_boot;
  assign tmr_voter_enable_o = (|hart_voter_en) || mode_boot;
  assign start_boot_o       = |hart_boot;

endmodule

//--- verification/safe_mode_ctrl_asserts.sv
`timescale 1ns/1ps
/* Output checks bound into the controller top level.
   The reset check fires on the first clock edge after reset release. */

module safe_mode_ctrl_asserts (
  input logic                     clk_i,
  input logic                     rst_ni,
  input safe_ctrl_pkg::hart_vec_t interrupt_halt_o,
  input safe_ctrl_pkg::hart_vec_t interrupt_swresync_o,
  input logic                     single_bus_o,
  input logic                     tmr_voter_enable_o,
  input logic                     start_boot_o,
  input logic                     en_ext_debug_req_o
);

  // Debug only from idle, never while cores are halted
  a_debug_not_halt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(en_ext_debug_req_o && (|interrupt_halt_o)))
    else $error("debug enable raised together with a halt request");

  // No core resyncs while any core is still being halted
  a_resync_not_halt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !((|interrupt_swresync_o) && (|interrupt_halt_o)))
    else $error("resync interrupt raised together with a halt request");

  a_low_after_reset: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !(single_bus_o || tmr_voter_enable_o || start_boot_o ||
      en_ext_debug_req_o || (|interrupt_halt_o) || (|interrupt_swresync_o)))
    else $error("control output high in the first cycle after reset");

endmodule

bind safe_mode_ctrl safe_mode_ctrl_asserts u_asserts (
  .clk_i                (clk_i),
  .rst_ni               (rst_ni),
  .interrupt_halt_o     (interrupt_halt_o),
  .interrupt_swresync_o (interrupt_swresync_o),
  .single_bus_o         (single_bus_o),
  .tmr_voter_enable_o   (tmr_voter_enable_o),
  .start_boot_o         (start_boot_o),
  .en_ext_debug_req_o   (en_ext_debug_req_o)
);

//--- verification/safe_mode_ctrl_tb.sv
`timescale 1ns/1ps
/* Random core responder plus a cycle model of the controller.
   Inputs change 10 ns after each rising edge, outputs are compared mid-cycle. */

`include "safe_ctrl_macros.svh"

module safe_mode_ctrl_tb;

  import safe_ctrl_pkg::*;

  localparam int NH         = `SAFE_NHARTS;
  localparam int MAX_CYCLES = 20 * `SAFE_TB_STEPS;

  logic      clk_i, rst_ni, start_i, tmr_critical_section_i, tmr_error_i, end_sw_routine_i;
  safe_cfg_t safe_cfg_i;
  hart_vec_t halt_ack_i, hart_wfi_i, hart_intc_ack_i, interrupt_halt_o, interrupt_swresync_o;
  logic      single_bus_o, tmr_voter_enable_o, start_boot_o, en_ext_debug_req_o;

  logic      rst_nx, start_nx, crit_nx, err_nx, end_nx, wfi_en; // Next drive slot
  logic      ack_release; // All cores acked the resync
  safe_cfg_t cfg_nx;
  int        hdly [NH];
  int        idly [NH];
  integer    seed = 13453;
  int        cycles, checks, errors;
  string     test_name;

  mode_state_e m_mode;
  tmr_state_e  m_core [NH];
  logic        m_err_q, m_edge;

  safe_mode_ctrl uut (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  function automatic int rand_delay();
    return 1 + ($random(seed) & 3);
  endfunction

  task automatic check_vec(input string sig, input hart_vec_t exp, input hart_vec_t act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("** Error [%s] %s: expected %b, actual %b", test_name, sig, exp, act);
    end
  endtask

  task automatic check_bit(input string sig, input logic exp, input logic act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("** Error [%s] %s: expected %b, actual %b", test_name, sig, exp, act);
    end
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////
  task automatic reset_model();
    m_mode  = MODE_RESET;
    m_err_q = 1'b0;
    m_edge  = 1'b0;
    foreach (m_core[i])
      m_core[i] = TMR_RESET;
  endtask

  task automatic model_step();
    hart_vec_t in_sync, idle;
    logic      run, rise, ferr;
    for (int i = 0; i < NH; i++)
    begin
      in_sync[i] = (m_core[i] == TMR_SYNC);
      idle[i]    = (m_core[i] == TMR_IDLE);
    end
    run  = (m_mode == MODE_TMR) && start_i;
    rise = tmr_error_i && !m_err_q;
    ferr = tmr_critical_section_i ? (rise && m_edge) : (tmr_error_i || m_edge);
    for (int i = 0; i < NH; i++)
      case (m_core[i])
        TMR_RESET:    m_core[i] = TMR_IDLE;
        TMR_IDLE:     if (run) m_core[i] = TMR_START;
        TMR_START:    if (halt_ack_i[i]) m_core[i] = TMR_BOOT;
        TMR_BOOT:     if (!halt_ack_i[i]) m_core[i] = TMR_SYNC;
        TMR_SYNC:     if (&hart_wfi_i && end_sw_routine_i) m_core[i] = TMR_IDLE;
                      else if (ferr) m_core[i] = TMR_SYNCINTC;
        TMR_SYNCINTC: if (&hart_intc_ack_i) m_core[i] = TMR_SWSYNC;
        TMR_SWSYNC:   if (!(|hart_intc_ack_i)) m_core[i] = TMR_SYNC;
        default:      ;
      endcase
    if (|in_sync && rise)
      {m_err_q, m_edge} = {1'b1, !m_edge}; // Edge flag toggles
    else if (!(&in_sync))
      {m_err_q, m_edge} = 2'b00;
    else
      m_err_q = tmr_error_i;
    case (m_mode)
      MODE_RESET: m_mode = MODE_BOOT;
      MODE_BOOT:  if (&hart_wfi_i) m_mode = MODE_IDLE;
      MODE_IDLE:  if (start_i && safe_cfg_i == `SAFE_CFG_TMR) m_mode = MODE_TMR;
      MODE_TMR:   if (&idle && !start_i) m_mode = MODE_IDLE;
      default:    ;
    endcase
  endtask

  task automatic compare_outputs();
    hart_vec_t e_halt, e_resync;
    logic      e_active, e_boot;
    e_active = (m_mode == MODE_BOOT);
    e_boot   = 1'b0;
    for (int i = 0; i < NH; i++)
    begin
      e_halt[i]   = (m_core[i] == TMR_START);
      e_resync[i] = (m_core[i] inside {TMR_SYNCINTC, TMR_SWSYNC});
      e_boot      |= (m_core[i] inside {TMR_START, TMR_BOOT});
      e_active    |= !(m_core[i] inside {TMR_RESET, TMR_IDLE});
    end
    check_vec("interrupt_halt_o", e_halt, interrupt_halt_o);
    check_vec("interrupt_swresync_o", e_resync, interrupt_swresync_o);
    check_bit("single_bus_o", e_active, single_bus_o);
    check_bit("tmr_voter_enable_o", e_active, tmr_voter_enable_o);
    check_bit("start_boot_o", e_boot, start_boot_o);
    check_bit("en_ext_debug_req_o", m_mode == MODE_IDLE, en_ext_debug_req_o);
  endtask

  //////////////////////////////////////////////////
  // Core responder and input drive
  //////////////////////////////////////////////////
  task automatic drive_inputs();
    logic want;
    ack_release = ack_release ? (|interrupt_swresync_o) : (&hart_intc_ack_i);
    for (int i = 0; i < NH; i++)
    begin
      // Halt ack follows the request, both edges after a random delay
      if (halt_ack_i[i] == interrupt_halt_o[i])
        hdly[i] = rand_delay();
      else
      begin
        hdly[i]--;
        if (hdly[i] <= 0)
        begin
          halt_ack_i[i] = interrupt_halt_o[i];
          hdly[i]       = rand_delay(); // Fresh delay for the release
        end
      end
      want = interrupt_swresync_o[i] && !ack_release;
      if (hart_intc_ack_i[i] == want)
        idly[i] = rand_delay();
      else
      begin
        idly[i]--;
        if (idly[i] <= 0)
          hart_intc_ack_i[i] = want;
      end
      if (!wfi_en)
        hart_wfi_i[i] = 1'b0;
      else if (($random(seed) & 1) != 0)
        hart_wfi_i[i] = 1'b1; // Cores reach wfi one by one
    end
    rst_ni                 = rst_nx;
    start_i                = start_nx;
    safe_cfg_i             = cfg_nx;
    tmr_critical_section_i = crit_nx;
    tmr_error_i            = err_nx;
    end_sw_routine_i       = end_nx;
  endtask

  task automatic tick();
    @(posedge clk_i);
    if (!rst_ni)
      reset_model();
    else
      model_step();
    #10;
    drive_inputs();
    #40;
    compare_outputs();
  endtask

  initial
  begin
    {rst_ni, start_i, tmr_critical_section_i, tmr_error_i, end_sw_routine_i} = '0;
    {rst_nx, start_nx, crit_nx, err_nx, end_nx, wfi_en, ack_release} = '0;
    safe_cfg_i = `SAFE_CFG_SINGLE;
    cfg_nx     = `SAFE_CFG_SINGLE;
    {halt_ack_i, hart_wfi_i, hart_intc_ack_i} = '0;
    checks = 0;
    errors = 0;
    reset_model();
    test_name = "boot";
    tick();
    rst_nx = 1'b1; // Released after the second edge
    tick();
    wfi_en = 1'b1;
    while (!en_ext_debug_req_o) tick();
    wfi_en    = 1'b0;
    test_name = "ignored cfg";
    start_nx  = 1'b1;
    repeat (5) tick();
    check_vec("no halt request", '0, interrupt_halt_o);
    check_bit("still idle", 1'b1, en_ext_debug_req_o);
    test_name = "tmr entry";
    cfg_nx    = `SAFE_CFG_TMR;
    repeat (2) tick(); // Start driven, then mode reaches TMR
    check_vec("halt after one edge", '0, interrupt_halt_o);
    tick();
    check_vec("halt after two edges", '1, interrupt_halt_o);
    while (start_boot_o) tick();
    check_bit("voter on in sync", 1'b1, tmr_voter_enable_o);
    test_name = "error outside critical section";
    err_nx    = 1'b1;
    tick();
    err_nx = 1'b0;
    while (interrupt_swresync_o == '0) tick();
    check_vec("resync on all cores", '1, interrupt_swresync_o);
    while (interrupt_swresync_o != '0) tick();
    test_name = "error in critical section";
    crit_nx   = 1'b1;
    tick();
    err_nx = 1'b1;
    tick();
    err_nx = 1'b0;
    repeat (3) tick();
    check_vec("first edge ignored", '0, interrupt_swresync_o);
    err_nx = 1'b1;
    tick();
    err_nx = 1'b0;
    while (interrupt_swresync_o == '0) tick();
    while (interrupt_swresync_o != '0) tick();
    test_name = "orderly end";
    {crit_nx, start_nx} = 2'b00;
    {end_nx, wfi_en}    = 2'b11;
    while (!en_ext_debug_req_o) tick();
    check_bit("bus split again", 1'b0, single_bus_o);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

  // Run limit from the scenario length
  initial
  begin
    cycles = 0;
    while (cycles < MAX_CYCLES)
    begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout: the DUT gave no response within %0d cycles", MAX_CYCLES);
    $display("checks: %0d, errors: %0d", checks, errors);
    $display("sim failed");
    $finish;
  end

endmodule

//--- project.f
+incdir+include
rtl/safe_ctrl_pkg.sv
rtl/safety_mode_fsm.sv
rtl/tmr_hart_fsm.sv
rtl/tmr_error_filter.sv
rtl/safe_mode_ctrl.sv
verification/safe_mode_ctrl_asserts.sv
verification/safe_mode_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the run by its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f project.f --top-module safe_mode_ctrl_tb \
  -o safe_mode_ctrl_sim > build.log 2>&1 &&
  ./obj_dir/safe_mode_ctrl_sim > sim.log 2>&1
grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL, see build.log and sim.log"; exit 1; }
